/* compile.f */
hw/ssd_ctrl_pkg.sv
hw/axil_reg_slave.sv
hw/cmd_launcher.sv
hw/watchdog_timer.sv
hw/ssd_ctrl_top.sv
verification/tb_clkgen.sv
verification/tb_ssd_ctrl.sv

/* Makefile */
.PHONY: help test clean

help:
	@echo "make test   build with Verilator, run the testbench, check sim.log"
	@echo "make clean  remove obj_dir and sim.log"
	@echo "make help   show this list"

test:
	verilator --binary --timing --assert -Wno-fatal --top-module tb_ssd_ctrl \
	  -f compile.f -Mdir obj_dir
	./obj_dir/Vtb_ssd_ctrl | tee sim.log
	grep -q "Simulation passed" sim.log

clean:
	rm -rf obj_dir sim.log

/* verification/tb_ssd_ctrl.sv */
`timescale 1ns/1ns

module tb_ssd_ctrl import ssd_ctrl_pkg::*; ();

  localparam int WDT_TIMEOUT = 200;
  localparam int WDT_PULSE   = 10;

  typedef enum {ROW_READ, ROW_LAUNCH, ROW_WDT, ROW_HP, ROW_BUTTON} row_kind_e;
  typedef struct {
    row_kind_e kind;
    reg_idx_t  idx;
    reg_word_t value;    // Write data, launch delay or clear bit
    reg_word_t exp_val;
  } row_t;

  logic       clk, rstn;
  logic       arvalid_i, rready_i, awvalid_i, wvalid_i, bready_i, switch_button_i;
  logic       arready_o, rvalid_o, awready_o, wready_o, bvalid_o;
  logic       cmd_valid_o, core_reset_o, hp_axi_reset_o;
  logic [3:0] wstrb_i;
  reg_addr_t  araddr_i, awaddr_i;
  reg_word_t  wdata_i, rdata_o, cmd_opcode_o, cmd_data0_o, cmd_data1_o;
  reg_word_t  core_state0_i, core_state1_i, core_state2_i, core_state3_i;
  axi_resp_t  rresp_o, bresp_o;
  int         cycle_cnt = 0;
  int         errors = 0;
  int         timeouts = 0;
  int         launch_hits = 0;
  int         bvalid_cycle, launch_cycle;
  reg_word_t  launch_words [3];
  row_t       rows [$];
  event       run_done;

  tb_clkgen u_clkgen (.clk(clk), .rstn(rstn));

  ssd_ctrl_top #(
    .TIMEOUT_CYCLES(wdt_cnt_t'(WDT_TIMEOUT)),
    .PULSE_CYCLES  (wdt_pulse_t'(WDT_PULSE))
  ) dut0 (.*);

  always @(posedge clk) cycle_cnt <= cycle_cnt + 1;

  // Strobe sampled mid-cycle where the outputs are settled
  always @(negedge clk) begin
    if (cmd_valid_o === 1'b1) begin
      launch_hits++;
      launch_cycle = cycle_cnt;
      launch_words = '{cmd_opcode_o, cmd_data0_o, cmd_data1_o};
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Bus and check tasks
  ////////////////////////////////////////////////////////////////////////////

  task automatic finish_run();
    $display("Errors: %0d, timeouts: %0d", errors, timeouts);
    if (errors == 0 && timeouts == 0) $display("Simulation passed");
    else $display("Simulation failed");
    $finish;
  endtask

  // Closing report for a normal end and for a timeout
  initial begin
    @(run_done);
    finish_run();
  end

  task automatic check_equal(input string what, input reg_word_t got, input reg_word_t exp_val);
    if (got !== exp_val) begin
      errors++;
      $display("Mismatch at %0t: %s is %h, expected %h", $time, what, got, exp_val);
    end
  endtask

  task automatic next_cycle(inout int cycles, input int limit, input string what);
    @(posedge clk);
    #1;                                   // Drive point
    cycles++;
    if (cycles > limit) begin
      timeouts++;
      $display("Timeout after %0d cycles waiting for %s", limit, what);
      -> run_done;
      forever @(posedge clk);             // Held here until the run ends
    end
  endtask

  task automatic write_reg(input reg_idx_t idx, input reg_word_t data);
    int   cycles;
    logic aw_take, w_take;
    cycles    = 0;
    awaddr_i  = reg_addr_t'(idx) << 2;   // Word index in bits 4 to 2
    wdata_i   = data;
    awvalid_i = 1'b1;
    wvalid_i  = 1'b1;
    while (awvalid_i || wvalid_i) begin
      aw_take = awvalid_i && awready_o;  // Taken on the coming edge
      w_take  = wvalid_i && wready_o;
      next_cycle(cycles, 20, "write address and data handshake");
      if (aw_take) awvalid_i = 1'b0;
      if (w_take) wvalid_i = 1'b0;
    end
    bready_i = 1'b1;
    while (!bvalid_o) next_cycle(cycles, 40, "write response");
    bvalid_cycle = cycle_cnt;
    check_equal("bresp", bresp_o, 0);
    next_cycle(cycles, 40, "write response");
    bready_i = 1'b0;
  endtask

  task automatic read_reg(input reg_idx_t idx, output reg_word_t data);
    int cycles;
    cycles    = 0;
    araddr_i  = reg_addr_t'(idx) << 2;
    arvalid_i = 1'b1;
    while (!arready_o) next_cycle(cycles, 20, "read address handshake");
    next_cycle(cycles, 20, "read address handshake");
    arvalid_i = 1'b0;
    rready_i  = 1'b1;
    while (!rvalid_o) next_cycle(cycles, 40, "read data");
    data = rdata_o;
    check_equal("rresp", rresp_o, 0);
    next_cycle(cycles, 40, "read data");
    rready_i = 1'b0;
  endtask

  task automatic launch_command(input int delay);
    reg_word_t words [3];
    reg_word_t cmd_word;
    reg_word_t rd;
    int        hits, cycles;
    foreach (words[i]) begin
      words[i] = $urandom;
      write_reg(reg_idx_t'(1 + i), words[i]);  // Opcode, data0, data1
    end
    write_reg(3'd4, delay);
    cmd_word = $urandom;
    hits     = launch_hits;
    cycles   = 0;
    write_reg(3'd0, cmd_word);
    while (launch_hits == hits) next_cycle(cycles, delay + 20, "command strobe");
    repeat (4) @(posedge clk);  // Room for a second strobe
    #1;
    check_equal("strobe count", launch_hits - hits, 1);
    check_equal("strobe delay after bvalid", launch_cycle - bvalid_cycle, delay + 1);
    foreach (words[i]) begin
      check_equal($sformatf("command word %0d", i), launch_words[i], words[i]);
    end
    read_reg(3'd0, rd);
    check_equal("word 0 readback", rd, cmd_word);
  endtask

  task automatic run_watchdog(input logic clear, input int exp_high);
    int cycles, start, high;
    cycles = 0;
    high   = 0;
    write_reg(3'd5, clear);
    write_reg(3'd6, 1);
    start = bvalid_cycle;
    if (clear) begin
      repeat (500) begin
        if (core_reset_o) high++;
        @(posedge clk);
        #1;
      end
    end else begin
      while (!core_reset_o) next_cycle(cycles, WDT_TIMEOUT + 10, "watchdog reset pulse");
      check_equal("watchdog pulse start in window", cycle_cnt - start >= WDT_TIMEOUT &&
                  cycle_cnt - start <= WDT_TIMEOUT + 3, 1);
      cycles = 0;
      while (core_reset_o) begin
        high++;
        next_cycle(cycles, WDT_PULSE + 10, "end of watchdog pulse");
      end
    end
    check_equal("core_reset_o high cycles", high, exp_high);
    write_reg(3'd6, 0);
    write_reg(3'd5, 0);
  endtask

  task automatic press_button();
    int cycles;
    cycles          = 0;
    switch_button_i = 1'b1;
    while (!core_reset_o && cycles < 2) next_cycle(cycles, 2, "button reset");
    check_equal("core_reset_o with button held", core_reset_o, 1);
    switch_button_i = 1'b0;
    while (core_reset_o) next_cycle(cycles, 10, "core reset release");
  endtask

  initial begin
    reg_word_t rd;
    int        cycles;
    void'($urandom(32'hd214_87fb));
    {arvalid_i, rready_i, awvalid_i, wvalid_i, bready_i, switch_button_i} = '0;
    araddr_i      = '0;
    awaddr_i      = '0;
    wdata_i       = '0;
    wstrb_i       = 4'hf;
    core_state0_i = $urandom;
    core_state1_i = $urandom;
    core_state2_i = $urandom;
    core_state3_i = $urandom;

    rows.push_back(row_t'{ROW_READ, 3'd0, 0, 32'hDEADBEEF});
    rows.push_back(row_t'{ROW_READ, 3'd1, 0, core_state0_i});
    rows.push_back(row_t'{ROW_READ, 3'd2, 0, core_state1_i});
    rows.push_back(row_t'{ROW_READ, 3'd3, 0, core_state2_i});
    rows.push_back(row_t'{ROW_READ, 3'd4, 0, core_state3_i});
    rows.push_back(row_t'{ROW_READ, 3'd5, 0, 0});
    rows.push_back(row_t'{ROW_READ, 3'd6, 0, 0});
    rows.push_back(row_t'{ROW_READ, 3'd7, 0, 0});
    rows.push_back(row_t'{ROW_LAUNCH, 3'd0, 0, 0});
    rows.push_back(row_t'{ROW_LAUNCH, 3'd0, 1, 0});
    rows.push_back(row_t'{ROW_LAUNCH, 3'd0, 5, 0});
    rows.push_back(row_t'{ROW_WDT, 3'd5, 0, WDT_PULSE});  // Starved watchdog gives one full pulse
    rows.push_back(row_t'{ROW_WDT, 3'd5, 1, 0});
    rows.push_back(row_t'{ROW_HP, 3'd7, 1, 1});
    rows.push_back(row_t'{ROW_HP, 3'd7, 0, 0});
    rows.push_back(row_t'{ROW_BUTTON, 3'd0, 1, 1});

    cycles = 0;
    while (rstn !== 1'b1) next_cycle(cycles, 40, "reset release");
    next_cycle(cycles, 40, "reset release");
    check_equal("cmd_valid_o after reset", cmd_valid_o, 0);
    check_equal("core_reset_o after reset", core_reset_o, 0);
    check_equal("hp_axi_reset_o after reset", hp_axi_reset_o, 0);
    check_equal("arready_o after reset", arready_o, 1);
    check_equal("awready_o after reset", awready_o, 1);
    check_equal("wready_o after reset", wready_o, 1);
    check_equal("rvalid_o after reset", rvalid_o, 0);
    check_equal("bvalid_o after reset", bvalid_o, 0);

    foreach (rows[n]) begin
      case (rows[n].kind)
        ROW_READ: begin
          read_reg(rows[n].idx, rd);
          check_equal($sformatf("read of word %0d", rows[n].idx), rd, rows[n].exp_val);
        end
        ROW_LAUNCH: launch_command(rows[n].value);
        ROW_WDT: run_watchdog(rows[n].value[0], rows[n].exp_val);
        ROW_HP: begin
          write_reg(rows[n].idx, rows[n].value);
          check_equal("hp_axi_reset_o", hp_axi_reset_o, rows[n].exp_val);
        end
        ROW_BUTTON: press_button();
      endcase
    end
    -> run_done;
  end

endmodule

/* verification/tb_clkgen.sv */
`timescale 1ns/1ns

module tb_clkgen #(
  parameter int PERIOD_NS    = 8,
  parameter int RESET_CYCLES = 16
) (
  output logic clk,
  output logic rstn
);

  initial begin
    clk = 1'b0;
    forever #(PERIOD_NS / 2) clk = ~clk;
  end

  // Released 1 ns after an edge like every other input
  initial begin
    rstn = 1'b0;
    repeat (RESET_CYCLES) @(posedge clk);
    #1;
    rstn = 1'b1;
  end

endmodule

/* hw/ssd_ctrl_top.sv */
`timescale 1ns/1ns

module ssd_ctrl_top import ssd_ctrl_pkg::*; #(
  parameter wdt_cnt_t   TIMEOUT_CYCLES = WDT_TIMEOUT_CYCLES,
  parameter wdt_pulse_t PULSE_CYCLES   = WDT_PULSE_CYCLES
) (
  input  logic       clk,
  input  logic       rstn,
  // AXI-lite slave port
  input  logic       arvalid_i,
  input  reg_addr_t  araddr_i,
  output logic       arready_o,
  output logic       rvalid_o,
  output reg_word_t  rdata_o,
  output axi_resp_t  rresp_o,
  input  logic       rready_i,
  input  logic       awvalid_i,
  input  reg_addr_t  awaddr_i,
  output logic       awready_o,
  input  logic       wvalid_i,
  input  reg_word_t  wdata_i,
  input  logic [3:0] wstrb_i,
  output logic       wready_o,
  output logic       bvalid_o,
  output axi_resp_t  bresp_o,
  input  logic       bready_i,
  // Storage core side
  input  reg_word_t  core_state0_i,
  input  reg_word_t  core_state1_i,
  input  reg_word_t  core_state2_i,
  input  reg_word_t  core_state3_i,
  input  logic       switch_button_i,
  output logic       cmd_valid_o,
  output reg_word_t  cmd_opcode_o,
  output reg_word_t  cmd_data0_o,
  output reg_word_t  cmd_data1_o,
  output logic       core_reset_o,
  output logic       hp_axi_reset_o
);

  logic      cmd_new;
  reg_word_t opcode;
  reg_word_t data0;
  reg_word_t data1;
  reg_word_t delay;
  logic      wdt_clear;
  logic      wdt_enable;

  axil_reg_slave u_regs (
    .clk            (clk),            .rstn          (rstn),
    .arvalid_i      (arvalid_i),      .araddr_i      (araddr_i),
    .arready_o      (arready_o),      .rvalid_o      (rvalid_o),
    .rdata_o        (rdata_o),        .rresp_o       (rresp_o),
    .rready_i       (rready_i),       .awvalid_i     (awvalid_i),
    .awaddr_i       (awaddr_i),       .awready_o     (awready_o),
    .wvalid_i       (wvalid_i),       .wdata_i       (wdata_i),
    .wstrb_i        (wstrb_i),        .wready_o      (wready_o),
    .bvalid_o       (bvalid_o),       .bresp_o       (bresp_o),
    .bready_i       (bready_i),
    .core_state0_i  (core_state0_i),  .core_state1_i (core_state1_i),
    .core_state2_i  (core_state2_i),  .core_state3_i (core_state3_i),
    .cmd_new_o      (cmd_new),        .opcode_o      (opcode),
    .data0_o        (data0),          .data1_o       (data1),
    .delay_o        (delay),          .wdt_clear_o   (wdt_clear),
    .wdt_enable_o   (wdt_enable),     .hp_axi_reset_o(hp_axi_reset_o)
  );

  cmd_launcher u_launcher (
    .clk          (clk),          .rstn        (rstn),
    .cmd_new_i    (cmd_new),      .opcode_i    (opcode),
    .data0_i      (data0),        .data1_i     (data1),
    .delay_i      (delay),        .cmd_valid_o (cmd_valid_o),
    .cmd_opcode_o (cmd_opcode_o), .cmd_data0_o (cmd_data0_o),
    .cmd_data1_o  (cmd_data1_o)
  );

  watchdog_timer #(
    .TIMEOUT_CYCLES(TIMEOUT_CYCLES),
    .PULSE_CYCLES  (PULSE_CYCLES)
  ) u_wdt (
    .clk           (clk),
    .rstn          (rstn),
    .enable_i      (wdt_enable),
    .clear_i       (wdt_clear),
    .manual_reset_i(switch_button_i),
    .core_reset_o  (core_reset_o)
  );

endmodule

/* hw/watchdog_timer.sv */
`timescale 1ns/1ns

module watchdog_timer import ssd_ctrl_pkg::*; #(
  parameter wdt_cnt_t   TIMEOUT_CYCLES = WDT_TIMEOUT_CYCLES,
  parameter wdt_pulse_t PULSE_CYCLES   = WDT_PULSE_CYCLES
) (
  input  logic clk,
  input  logic rstn,
  input  logic enable_i,
  input  logic clear_i,
  input  logic manual_reset_i,
  output logic core_reset_o
);

  wdt_cnt_t   cnt_q;
  wdt_pulse_t pulse_q;
  logic       rst_int_q;
  logic       expired;

  assign expired = (cnt_q == wdt_cnt_t'(TIMEOUT_CYCLES - 1'b1));

  ////////////////////////////////////////////////////////////////////////////
  // Timeout counter and pulse stretcher
  ////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk) begin
    if (!rstn) begin
      cnt_q     <= '0;
      pulse_q   <= '0;
      rst_int_q <= 1'b0;
    end else begin
      rst_int_q <= (pulse_q != '0);
      if (pulse_q != '0) begin
        // Count stays parked while the reset pulse runs
        pulse_q <= pulse_q - 1'b1;
        cnt_q   <= '0;
      end else if (enable_i && !clear_i) begin
        if (expired) begin
          cnt_q   <= '0;
          pulse_q <= PULSE_CYCLES;
        end else begin
          cnt_q <= cnt_q + 1'b1;
        end
      end else begin
        cnt_q <= '0;  // Software kicked it or it is off
      end
    end
  end

  // Button joins here one cycle behind
  always_ff @(posedge clk) begin
    if (!rstn) core_reset_o <= 1'b0;
    else core_reset_o <= rst_int_q | manual_reset_i;
  end

  clear_holds_count_a: assert property (@(posedge clk) disable iff (!rstn)
    clear_i |=> cnt_q == '0);

endmodule

/* hw/cmd_launcher.sv */
`timescale 1ns/1ns

module cmd_launcher import ssd_ctrl_pkg::*; (
  input  logic      clk,
  input  logic      rstn,
  input  logic      cmd_new_i,
  input  reg_word_t opcode_i,
  input  reg_word_t data0_i,
  input  reg_word_t data1_i,
  input  reg_word_t delay_i,
  output logic      cmd_valid_o,
  output reg_word_t cmd_opcode_o,
  output reg_word_t cmd_data0_o,
  output reg_word_t cmd_data1_o
);

  logic      pending_q;
  reg_word_t count_q;

  // A new command restarts the countdown
  always_ff @(posedge clk) begin
    if (!rstn) begin
      pending_q <= 1'b0;
      count_q   <= '0;
    end else if (cmd_new_i) begin
      pending_q <= 1'b1;
      count_q   <= delay_i;
    end else if (pending_q) begin
      if (count_q == '0) pending_q <= 1'b0;  // Issued this cycle
      else count_q <= count_q - 1'b1;
    end
  end

  always_ff @(posedge clk) begin
    if (cmd_new_i) begin
      cmd_opcode_o <= opcode_i;
      cmd_data0_o  <= data0_i;
      cmd_data1_o  <= data1_i;
    end
  end

  assign cmd_valid_o = pending_q && (count_q == '0);

  cmd_valid_single_a: assert property (@(posedge clk) disable iff (!rstn)
    cmd_valid_o |=> !cmd_valid_o);

endmodule

/* hw/axil_reg_slave.sv */
`timescale 1ns/1ns

module axil_reg_slave import ssd_ctrl_pkg::*; (
  input  logic      clk,
  input  logic      rstn,
  // Read channels
  input  logic      arvalid_i,
  input  reg_addr_t araddr_i,
  output logic      arready_o,
  output logic      rvalid_o,
  output reg_word_t rdata_o,
  output axi_resp_t rresp_o,
  input  logic      rready_i,
  // Write channels
  input  logic      awvalid_i,
  input  reg_addr_t awaddr_i,
  output logic      awready_o,
  input  logic      wvalid_i,
  input  reg_word_t wdata_i,
  input  logic [3:0] wstrb_i,
  output logic      wready_o,
  output logic      bvalid_o,
  output axi_resp_t bresp_o,
  input  logic      bready_i,
  // Core state words
  input  reg_word_t core_state0_i,
  input  reg_word_t core_state1_i,
  input  reg_word_t core_state2_i,
  input  reg_word_t core_state3_i,
  // Launcher and watchdog side
  output logic      cmd_new_o,
  output reg_word_t opcode_o,
  output reg_word_t data0_o,
  output reg_word_t data1_o,
  output reg_word_t delay_o,
  output logic      wdt_clear_o,
  output logic      wdt_enable_o,
  output logic      hp_axi_reset_o
);

  rd_state_e rd_state;
  wr_state_e wr_state;
  reg_word_t arg_q [REG_NUM];
  reg_idx_t  rd_idx;
  reg_word_t rd_word;
  reg_idx_t  wr_idx_q;
  reg_word_t wr_data_q;
  logic      aw_got_q;
  logic      w_got_q;
  logic      ar_hs;
  logic      aw_hs;
  logic      w_hs;

  assign ar_hs = arvalid_i && arready_o;
  assign aw_hs = awvalid_i && awready_o;
  assign w_hs  = wvalid_i && wready_o;

  ////////////////////////////////////////////////////////////////////////////
  // Read path
  ////////////////////////////////////////////////////////////////////////////

  assign rd_idx = araddr_i[REG_IDX_LSB +: $bits(reg_idx_t)];

  always_comb begin
    unique case (rd_idx)
      3'd0:    rd_word = arg_q[IDX_COMMAND];  // Echo of the command word
      3'd1:    rd_word = core_state0_i;
      3'd2:    rd_word = core_state1_i;
      3'd3:    rd_word = core_state2_i;
      3'd4:    rd_word = core_state3_i;
      default: rd_word = '0;
    endcase
  end

  always_ff @(posedge clk) begin
    if (!rstn) begin
      rd_state <= IDLE;
    end else begin
      unique case (rd_state)
        IDLE: if (ar_hs) rd_state <= DATA;
        DATA: if (rready_i) rd_state <= IDLE;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (ar_hs) rdata_o <= rd_word;
  end

  assign arready_o = (rd_state == IDLE);
  assign rvalid_o  = (rd_state == DATA);
  assign rresp_o   = RESP_OKAY;

  ////////////////////////////////////////////////////////////////////////////
  // Write path
  ////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk) begin
    if (!rstn) begin
      wr_state  <= COLLECT;
      aw_got_q  <= 1'b0;
      w_got_q   <= 1'b0;
      cmd_new_o <= 1'b0;
    end else begin
      cmd_new_o <= (wr_state == COMMIT) && (wr_idx_q == IDX_COMMAND);
      unique case (wr_state)
        COLLECT: begin
          if (aw_hs) aw_got_q <= 1'b1;
          if (w_hs) w_got_q <= 1'b1;
          if ((aw_got_q || aw_hs) && (w_got_q || w_hs)) wr_state <= COMMIT;
        end
        COMMIT: begin
          wr_state <= RESP;
          aw_got_q <= 1'b0;
          w_got_q  <= 1'b0;
        end
        RESP: if (bready_i) wr_state <= COLLECT;
        default: wr_state <= COLLECT;
      endcase
    end
  end

  // Address and data may arrive in either order
  always_ff @(posedge clk) begin
    if (aw_hs) wr_idx_q <= awaddr_i[REG_IDX_LSB +: $bits(reg_idx_t)];
    if (w_hs) wr_data_q <= wdata_i;
  end

  always_ff @(posedge clk) begin
    if (!rstn) begin
      arg_q[IDX_COMMAND] <= CMD_RESET_VALUE;
      wdt_clear_o        <= 1'b0;
      wdt_enable_o       <= 1'b0;
      hp_axi_reset_o     <= 1'b0;
    end else if (wr_state == COMMIT) begin
      unique case (wr_idx_q)
        IDX_WDT_CLEAR:  wdt_clear_o    <= wr_data_q[0];
        IDX_WDT_ENABLE: wdt_enable_o   <= wr_data_q[0];
        IDX_HP_RESET:   hp_axi_reset_o <= wr_data_q[0];
        default:        arg_q[wr_idx_q] <= wr_data_q;
      endcase
    end
  end

  assign awready_o = (wr_state == COLLECT) && !aw_got_q;
  assign wready_o  = (wr_state == COLLECT) && !w_got_q;
  assign bvalid_o  = (wr_state == RESP);
  assign bresp_o   = RESP_OKAY;

  assign opcode_o = arg_q[IDX_OPCODE];
  assign data0_o  = arg_q[IDX_DATA0];
  assign data1_o  = arg_q[IDX_DATA1];
  assign delay_o  = arg_q[IDX_DELAY];

  rvalid_hold_a: assert property (@(posedge clk) disable iff (!rstn)
    rvalid_o && !rready_i |=> rvalid_o && $stable(rdata_o));
  bvalid_hold_a: assert property (@(posedge clk) disable iff (!rstn)
    bvalid_o && !bready_i |=> bvalid_o);
  cmd_new_pulse_a: assert property (@(posedge clk) disable iff (!rstn)
    cmd_new_o |=> !cmd_new_o);

endmodule

/* hw/ssd_ctrl_pkg.sv */
package ssd_ctrl_pkg;

  ////////////////////////////////////////////////////////////////////////////
  // Widths
  ////////////////////////////////////////////////////////////////////////////

  typedef logic [31:0] reg_word_t;   // Register and bus data word
  typedef logic [31:0] reg_addr_t;   // AXI-lite byte address
  typedef logic [2:0]  reg_idx_t;
  typedef logic [1:0]  axi_resp_t;
  typedef logic [31:0] wdt_cnt_t;
  typedef logic [16:0] wdt_pulse_t;

  localparam int        REG_NUM     = 8;
  localparam int        REG_IDX_LSB = 2;  // Word aligned
  localparam axi_resp_t RESP_OKAY   = 2'b00;

  ////////////////////////////////////////////////////////////////////////////
  // Register map
  ////////////////////////////////////////////////////////////////////////////

  localparam reg_idx_t IDX_COMMAND    = 3'd0;  // Write launches a command
  localparam reg_idx_t IDX_OPCODE     = 3'd1;
  localparam reg_idx_t IDX_DATA0      = 3'd2;
  localparam reg_idx_t IDX_DATA1      = 3'd3;
  localparam reg_idx_t IDX_DELAY      = 3'd4;
  localparam reg_idx_t IDX_WDT_CLEAR  = 3'd5;
  localparam reg_idx_t IDX_WDT_ENABLE = 3'd6;
  localparam reg_idx_t IDX_HP_RESET   = 3'd7;

  localparam reg_word_t CMD_RESET_VALUE = 32'hDEADBEEF;

  // One second at 50 MHz
  localparam wdt_cnt_t   WDT_TIMEOUT_CYCLES = 32'd50_000_000;
  localparam wdt_pulse_t WDT_PULSE_CYCLES   = 17'd100_000;

  typedef enum logic {IDLE, DATA} rd_state_e;
  typedef enum logic [1:0] {COLLECT, COMMIT, RESP} wr_state_e;

endpackage
